//--- rv_id.f
common/rv_id_pkg.sv
decode/rv_id_decoder.sv
verilog/rv_id_regfile.sv
verilog/rv_id_operands.sv
verilog/rv_id_ctrl.sv
verilog/rv_id_top.sv
bench/rv_id_checker.sv
bench/rv_id_tb.sv

//--- Makefile
# Verilator build and run for the ID stage testbench

VERILATOR ?= verilator
TOP       ?= rv_id_tb
FILELIST  ?= rv_id.f
SIM_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

SRCS    := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(SIM_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(SIM_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "Simulation passed" $(LOG)

clean:
	rm -rf $(SIM_DIR) $(LOG)

//--- bench/rv_id_tb.sv
`timescale 1ns/1ns

module rv_id_tb
  import rv_id_pkg::*;
();

  logic        clk;
  logic        rst_n;
  if_id_pipe_t if_id_pipe;
  ctrl_fsm_t   ctrl_fsm;
  logic        ex_ready;
  logic        wb_we;
  rf_addr_t    wb_waddr;
  rf_data_t    wb_wdata;
  id_ex_pipe_t id_ex_pipe;
  logic        id_ready;
  logic        id_valid;
  int unsigned violations;

  // Model of what the bench wrote into the register file
  rf_data_t    regs [NUM_RF_REGS];
  logic [31:0] next_pc;
  logic [31:0] last_pc;
  int          seed;
  int unsigned errors;
  int unsigned tests_run;
  int unsigned tests_failed;

  rv_id_top rv_id_top_i (
    .clk          (clk),
    .rst_n_i      (rst_n),
    .if_id_pipe_i (if_id_pipe),
    .ctrl_fsm_i   (ctrl_fsm),
    .ex_ready_i   (ex_ready),
    .wb_we_i      (wb_we),
    .wb_waddr_i   (wb_waddr),
    .wb_wdata_i   (wb_wdata),
    .id_ex_pipe_o (id_ex_pipe),
    .id_ready_o   (id_ready),
    .id_valid_o   (id_valid)
  );

  rv_id_checker rv_id_checker_i (
    .clk          (clk),
    .rst_n_i      (rst_n),
    .ctrl_fsm_i   (ctrl_fsm),
    .id_ready_i   (id_ready),
    .id_valid_i   (id_valid),
    .id_ex_pipe_i (id_ex_pipe),
    .violations_o (violations)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // Encoders for the RV32 instruction formats
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] r_type(input logic [6:0] f7, input rf_addr_t rs2,
                                         input rf_addr_t rs1, input logic [2:0] f3,
                                         input rf_addr_t rd, input logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input rf_addr_t rs1,
                                         input logic [2:0] f3, input rf_addr_t rd,
                                         input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  // The store immediate is split around the rs fields
  function automatic logic [31:0] s_type(input logic [11:0] imm, input rf_addr_t rs2,
                                         input rf_addr_t rs1, input logic [2:0] f3,
                                         input logic [6:0] opc);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], opc};
  endfunction

  function automatic logic [31:0] u_type(input logic [19:0] imm, input rf_addr_t rd,
                                         input logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  // Bit order is alu, mul, lsu, lsu_we, rf_we, ecall, ebreak, mret, dret, wfi, fence.i, illegal
  function automatic logic [11:0] flags_of(input id_ex_pipe_t p);
    return {p.alu_en, p.mul_en, p.lsu_en, p.lsu_we, p.rf_we, p.ecall_insn, p.ebrk_insn,
            p.mret_insn, p.dret_insn, p.wfi_insn, p.fencei_insn, p.illegal_insn};
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Checking and driving
  //////////////////////////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("Mismatch at %0t ns: %s is 0x%08h, expected 0x%08h",
               $time, name, actual, expected);
      errors++;
    end
  endtask

  task automatic check_flags(input logic valid, input logic [11:0] flags,
                             input csr_opcode_e csr);
    check_value("id_ex_pipe_o.instr_valid", 32'(id_ex_pipe.instr_valid), 32'(valid));
    check_value("id_ex_pipe_o enables and flags", 32'(flags_of(id_ex_pipe)), 32'(flags));
    check_value("id_ex_pipe_o.csr_op", 32'(id_ex_pipe.csr_op), 32'(csr));
  endtask

  // Destination is always the rd field of the encoding
  task automatic check_pipe(input logic [31:0] pc, input logic [31:0] instr,
                            input logic [11:0] flags, input csr_opcode_e csr,
                            input rf_data_t op_a, input rf_data_t op_b);
    check_flags(1'b1, flags, csr);
    check_value("id_ex_pipe_o.operand_a", id_ex_pipe.operand_a, op_a);
    check_value("id_ex_pipe_o.operand_b", id_ex_pipe.operand_b, op_b);
    check_value("id_ex_pipe_o.rd", 32'(id_ex_pipe.rd), 32'(instr[11:7]));
    check_value("id_ex_pipe_o.pc", id_ex_pipe.pc, pc);
  endtask

  task automatic check_emerged(input logic [31:0] pc, input rf_addr_t rd);
    check_value("id_ex_pipe_o.instr_valid", 32'(id_ex_pipe.instr_valid), 32'd1);
    check_value("id_ex_pipe_o.pc", id_ex_pipe.pc, pc);
    check_value("id_ex_pipe_o.rd", 32'(id_ex_pipe.rd), 32'(rd));
  endtask

  task automatic write_reg(input rf_addr_t addr, input rf_data_t data);
    @(posedge clk);
    wb_we    <= 1'b1;
    wb_waddr <= addr;
    wb_wdata <= data;
    @(posedge clk);
    wb_we    <= 1'b0;
    regs[addr] = data;
  endtask

  // Called right after a rising edge
  task automatic present(input logic [31:0] instr, input logic dummy);
    if_id_pipe.instr_valid      <= 1'b1;
    if_id_pipe.instr            <= instr;
    if_id_pipe.pc               <= next_pc;
    if_id_pipe.instr_meta.dummy <= dummy;
    last_pc = next_pc;
    next_pc = next_pc + 32'd4;
  endtask

  // Returns on the falling edge before the edge that consumes the instruction
  task automatic wait_accept();
    int unsigned waited;
    waited = 0;
    @(negedge clk);
    while (!id_ready && waited < 20) begin
      @(negedge clk);
      waited++;
    end
    if (!id_ready) begin
      $display("Error at %0t ns: instruction was not accepted within 20 cycles", $time);
      errors++;
    end
  endtask

  // Present one instruction and stop on the falling edge where its result is registered
  task automatic issue(input logic [31:0] instr, input logic dummy);
    @(posedge clk);
    present(instr, dummy);
    wait_accept();
    @(posedge clk);
    if_id_pipe <= '0;
    @(negedge clk);
  endtask

  task automatic run_insn(input logic [31:0] instr, input logic dummy, input logic [11:0] flags,
                          input csr_opcode_e csr, input rf_data_t op_a, input rf_data_t op_b);
    issue(instr, dummy);
    check_pipe(last_pc, instr, flags, csr, op_a, op_b);
  endtask

  task automatic run_illegal(input logic [31:0] instr);
    issue(instr, 1'b0);
    check_flags(1'b1, 12'b0000_0000_0001, CSR_OP_READ);
  endtask

  task automatic report_test(input string name, input int unsigned start);
    tests_run++;
    if (errors == start) begin
      $display("%s: ok", name);
    end else begin
      tests_failed++;
      $display("%s: failed with %0d errors", name, errors - start);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic reset_state();
    int unsigned start;
    start = errors;
    @(negedge clk);
    check_flags(1'b0, 12'b0, CSR_OP_READ);
    report_test("reset_state", start);
  endtask

  task automatic decode_operands();
    int unsigned start;
    rf_data_t    r1;
    rf_data_t    r2;
    start = errors;
    write_reg(5'd1, $random(seed));
    write_reg(5'd2, $random(seed));
    r1 = regs[1];
    r2 = regs[2];
    run_insn(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3, OPC_OP), 1'b0,
             12'b1000_1000_0000, CSR_OP_READ, r1, r2);
    // ADDI with a negative immediate checks the sign extension
    run_insn(i_type(12'hffb, 5'd1, 3'b000, 5'd4, OPC_OP_IMM), 1'b0,
             12'b1000_1000_0000, CSR_OP_READ, r1, 32'hffff_fffb);
    run_insn(u_type(20'habcde, 5'd5, OPC_LUI), 1'b0,
             12'b1000_1000_0000, CSR_OP_READ, 32'd0, 32'habcd_e000);
    run_insn(i_type(12'h010, 5'd2, 3'b010, 5'd6, OPC_LOAD), 1'b0,
             12'b0010_1000_0000, CSR_OP_READ, r2, 32'h10);
    run_insn(s_type(12'h024, 5'd2, 5'd1, 3'b010, OPC_STORE), 1'b0,
             12'b0011_0000_0000, CSR_OP_READ, r1, 32'h24);
    run_insn(r_type(7'h01, 5'd2, 5'd1, 3'b000, 5'd8, OPC_OP), 1'b0,
             12'b0100_1000_0000, CSR_OP_READ, r1, r2);
    // System instructions read no register, so both operands stay zero
    run_insn(i_type(F12_ECALL, 5'd0, 3'b000, 5'd0, OPC_SYSTEM), 1'b0,
             12'b0000_0100_0000, CSR_OP_READ, 32'd0, 32'd0);
    run_insn(i_type(F12_EBREAK, 5'd0, 3'b000, 5'd0, OPC_SYSTEM), 1'b0,
             12'b0000_0010_0000, CSR_OP_READ, 32'd0, 32'd0);
    run_insn(i_type(F12_MRET, 5'd0, 3'b000, 5'd0, OPC_SYSTEM), 1'b0,
             12'b0000_0001_0000, CSR_OP_READ, 32'd0, 32'd0);
    run_insn(i_type(F12_DRET, 5'd0, 3'b000, 5'd0, OPC_SYSTEM), 1'b0,
             12'b0000_0000_1000, CSR_OP_READ, 32'd0, 32'd0);
    run_insn(i_type(F12_WFI, 5'd0, 3'b000, 5'd0, OPC_SYSTEM), 1'b0,
             12'b0000_0000_0100, CSR_OP_READ, 32'd0, 32'd0);
    run_insn(i_type(12'h000, 5'd0, 3'b001, 5'd0, OPC_MISC_MEM), 1'b0,
             12'b0000_0000_0010, CSR_OP_READ, 32'd0, 32'd0);
    // CSRRS carries the CSR address in operand B
    run_insn(i_type(12'h300, 5'd1, 3'b010, 5'd7, OPC_SYSTEM), 1'b0,
             12'b0000_1000_0000, CSR_OP_SET, r1, 32'h300);
    report_test("decode_operands", start);
  endtask

  task automatic illegal_encodings();
    int unsigned start;
    start = errors;
    run_illegal(32'h0000_007f);
    run_illegal(32'h0000_006f);
    // MULH and DIV are outside the subset
    run_illegal(r_type(7'h01, 5'd2, 5'd1, 3'b001, 5'd3, OPC_OP));
    run_illegal(r_type(7'h01, 5'd2, 5'd1, 3'b100, 5'd3, OPC_OP));
    run_illegal(i_type(12'h123, 5'd0, 3'b000, 5'd0, OPC_SYSTEM));
    run_illegal(i_type(12'h000, 5'd0, 3'b000, 5'd0, OPC_MISC_MEM));
    report_test("illegal_encodings", start);
  endtask

  task automatic x0_rule();
    int unsigned start;
    logic [31:0] add_w;
    start = errors;
    write_reg(5'd0, rf_data_t'($random(seed)) | 32'd1);
    add_w = r_type(7'h00, 5'd1, 5'd0, 3'b000, 5'd9, OPC_OP);
    run_insn(add_w, 1'b0, 12'b1000_1000_0000, CSR_OP_READ, 32'd0, regs[1]);
    run_insn(add_w, 1'b1, 12'b1000_1000_0000, CSR_OP_READ, regs[0], regs[1]);
    // Same rule on the second read port
    run_insn(r_type(7'h00, 5'd0, 5'd1, 3'b000, 5'd9, OPC_OP), 1'b0,
             12'b1000_1000_0000, CSR_OP_READ, regs[1], 32'd0);
    report_test("x0_rule", start);
  endtask

  // Kill alone or together with halt, the slot drains as a bubble
  task automatic kill_slot(input logic halt);
    @(posedge clk);
    ctrl_fsm.kill_id <= 1'b1;
    ctrl_fsm.halt_id <= halt;
    present(i_type(12'h001, 5'd1, 3'b000, 5'd4, OPC_OP_IMM), 1'b0);
    @(negedge clk);
    check_value("id_ready_o", 32'(id_ready), 32'd1);
    check_value("id_valid_o", 32'(id_valid), 32'd0);
    @(posedge clk);
    ctrl_fsm   <= '0;
    if_id_pipe <= '0;
    @(negedge clk);
    check_flags(1'b0, 12'b0, CSR_OP_READ);
  endtask

  task automatic halt_and_kill();
    int unsigned start;
    logic [31:0] add_w;
    logic [31:0] halted_pc;
    start = errors;
    add_w = r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3, OPC_OP);
    @(posedge clk);
    ctrl_fsm.halt_id <= 1'b1;
    present(add_w, 1'b0);
    halted_pc = last_pc;
    repeat (3) begin
      @(negedge clk);
      check_value("id_ready_o", 32'(id_ready), 32'd0);
      check_value("id_valid_o", 32'(id_valid), 32'd0);
    end
    check_flags(1'b0, 12'b0, CSR_OP_READ);
    // The held instruction goes through once halt drops
    @(posedge clk);
    ctrl_fsm.halt_id <= 1'b0;
    wait_accept();
    @(posedge clk);
    if_id_pipe <= '0;
    @(negedge clk);
    check_pipe(halted_pc, add_w, 12'b1000_1000_0000, CSR_OP_READ, regs[1], regs[2]);
    kill_slot(1'b0);
    kill_slot(1'b1);
    report_test("halt_and_kill", start);
  endtask

  task automatic back_pressure();
    int unsigned start;
    logic [31:0] pc_a;
    logic [31:0] pc_b;
    logic [31:0] pc_c;
    logic [31:0] pc_d;
    start = errors;
    @(posedge clk);
    present(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3, OPC_OP), 1'b0);
    pc_a = last_pc;
    wait_accept();
    // Execute stalls on the same edge that registers the ADD
    @(posedge clk);
    ex_ready <= 1'b0;
    present(i_type(12'h005, 5'd1, 3'b000, 5'd4, OPC_OP_IMM), 1'b0);
    pc_b = last_pc;
    // Stalled, the ADD stays in the register
    repeat (3) begin
      @(negedge clk);
      check_value("id_ready_o", 32'(id_ready), 32'd0);
      check_value("id_valid_o", 32'(id_valid), 32'd0);
      check_emerged(pc_a, 5'd3);
    end
    @(posedge clk);
    ex_ready <= 1'b1;
    wait_accept();
    @(posedge clk);
    present(u_type(20'h12345, 5'd5, OPC_LUI), 1'b0);
    pc_c = last_pc;
    @(negedge clk);
    check_emerged(pc_b, 5'd4);
    @(posedge clk);
    present(r_type(7'h01, 5'd2, 5'd1, 3'b000, 5'd8, OPC_OP), 1'b0);
    pc_d = last_pc;
    @(negedge clk);
    check_emerged(pc_c, 5'd5);
    @(posedge clk);
    if_id_pipe <= '0;
    @(negedge clk);
    check_emerged(pc_d, 5'd8);
    report_test("back_pressure", start);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  //////////////////////////////////////////////////////////////////////

  initial begin
    rst_n        = 1'b0;
    if_id_pipe   = '0;
    ctrl_fsm     = '0;
    ex_ready     = 1'b1;
    wb_we        = 1'b0;
    wb_waddr     = '0;
    wb_wdata     = '0;
    seed         = 32'h38ff;
    next_pc      = 32'h0000_1000;
    last_pc      = '0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    reset_state();
    decode_operands();
    illegal_encodings();
    x0_rule();
    halt_and_kill();
    back_pressure();
    $display("Tests run: %0d, tests failed: %0d, check errors: %0d, checker violations: %0d",
             tests_run, tests_failed, errors, violations);
    if (tests_failed == 0 && errors == 0 && violations == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin
    int unsigned budget;
    // Reset, about 4 cycles per issued instruction, 2 per register write,
    // and the fixed stall and halt waits; doubled for margin
    budget = 2 * (8 + 4 * 32 + 2 * 4 + 24);
    repeat (budget) @(posedge clk);
    $display("Timeout: the tests did not finish within %0d clock cycles", budget);
    $display("Simulation failed");
    $finish;
  end

endmodule

//--- bench/rv_id_checker.sv
`timescale 1ns/1ns

module rv_id_checker
  import rv_id_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n_i,
  input  ctrl_fsm_t   ctrl_fsm_i,
  input  logic        id_ready_i,
  input  logic        id_valid_i,
  input  id_ex_pipe_t id_ex_pipe_i,
  output int unsigned violations_o
);

  int unsigned count = 0;
  logic        side_effects;

  // Anything that would change state or redirect the core downstream
  assign side_effects = id_ex_pipe_i.alu_en || id_ex_pipe_i.mul_en || id_ex_pipe_i.lsu_en ||
                        id_ex_pipe_i.lsu_we || id_ex_pipe_i.rf_we ||
                        id_ex_pipe_i.ecall_insn || id_ex_pipe_i.ebrk_insn ||
                        id_ex_pipe_i.mret_insn || id_ex_pipe_i.dret_insn ||
                        id_ex_pipe_i.wfi_insn || id_ex_pipe_i.fencei_insn ||
                        (id_ex_pipe_i.csr_op != CSR_OP_READ);

  assign violations_o = count;

  //////////////////////////////////////////////////////////////////////
  // Stage rules
  //////////////////////////////////////////////////////////////////////

  // Sampled on the falling edge where the combinational outputs have settled
  always @(negedge clk) begin
    if (rst_n_i) begin
      if (id_ex_pipe_i.illegal_insn && side_effects) begin
        $display("Checker at %0t ns: illegal instruction leaves an enable or CSR op set", $time);
        count = count + 1;
      end
      // Halt on its own stalls the stage
      if (ctrl_fsm_i.halt_id && !ctrl_fsm_i.kill_id && (id_ready_i || id_valid_i)) begin
        $display("Checker at %0t ns: stage is ready or valid while halted", $time);
        count = count + 1;
      end
      // Kill drains the slot, whatever halt says
      if (ctrl_fsm_i.kill_id && (!id_ready_i || id_valid_i)) begin
        $display("Checker at %0t ns: stage is not ready or still valid under kill", $time);
        count = count + 1;
      end
    end
  end

endmodule

//--- verilog/rv_id_top.sv
`timescale 1ns/1ns

module rv_id_top
  import rv_id_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n_i,
  input  if_id_pipe_t if_id_pipe_i,
  input  ctrl_fsm_t   ctrl_fsm_i,
  input  logic        ex_ready_i,
  input  logic        wb_we_i,
  input  rf_addr_t    wb_waddr_i,
  input  rf_data_t    wb_wdata_i,
  output id_ex_pipe_t id_ex_pipe_o,
  output logic        id_ready_o,
  output logic        id_valid_o
);

  // Decoder result, shared by the operand block and the control block
  decode_t  decode;

  // Register file read ports
  rf_addr_t rf_raddr [NUM_READ_PORTS];
  rf_data_t rf_rdata [NUM_READ_PORTS];

  // Operands after the x0 rule and immediate selection
  rf_data_t operand_a;
  rf_data_t operand_b;

  rv_id_decoder rv_id_decoder_i (
    .instr_i  (if_id_pipe_i.instr),
    .decode_o (decode)
  );

  // Writeback comes straight from the top level ports
  rv_id_regfile rv_id_regfile_i (
    .clk     (clk),
    .raddr_i (rf_raddr),
    .rdata_o (rf_rdata),
    .we_i    (wb_we_i),
    .waddr_i (wb_waddr_i),
    .wdata_i (wb_wdata_i)
  );

  rv_id_operands rv_id_operands_i (
    .decode_i    (decode),
    .dummy_i     (if_id_pipe_i.instr_meta.dummy),
    .rdata_i     (rf_rdata),
    .raddr_o     (rf_raddr),
    .operand_a_o (operand_a),
    .operand_b_o (operand_b)
  );

  rv_id_ctrl rv_id_ctrl_i (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .if_id_pipe_i (if_id_pipe_i),
    .ctrl_fsm_i   (ctrl_fsm_i),
    .ex_ready_i   (ex_ready_i),
    .decode_i     (decode),
    .operand_a_i  (operand_a),
    .operand_b_i  (operand_b),
    .id_ex_pipe_o (id_ex_pipe_o),
    .id_ready_o   (id_ready_o),
    .id_valid_o   (id_valid_o)
  );

endmodule

//--- verilog/rv_id_ctrl.sv
`timescale 1ns/1ns

module rv_id_ctrl
  import rv_id_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n_i,
  input  if_id_pipe_t if_id_pipe_i,
  input  ctrl_fsm_t   ctrl_fsm_i,
  input  logic        ex_ready_i,
  input  decode_t     decode_i,
  input  rf_data_t    operand_a_i,
  input  rf_data_t    operand_b_i,
  output id_ex_pipe_t id_ex_pipe_o,
  output logic        id_ready_o,
  output logic        id_valid_o
);

  id_ex_pipe_t pipe_d;
  id_ex_pipe_t pipe_q;

  //////////////////////////////////////////////////////////////////////
  // Ready and valid
  //////////////////////////////////////////////////////////////////////

  // Kill flushes the slot, so the stage accepts regardless of halt
  always_comb begin
    if (ctrl_fsm_i.kill_id) begin
      id_ready_o = 1'b1;
    end else if (ctrl_fsm_i.halt_id) begin
      id_ready_o = 1'b0;
    end else begin
      id_ready_o = ex_ready_i;
    end
  end

  assign id_valid_o = if_id_pipe_i.instr_valid && ex_ready_i &&
                      !ctrl_fsm_i.halt_id && !ctrl_fsm_i.kill_id;

  //////////////////////////////////////////////////////////////////////
  // ID/EX pipe register
  //////////////////////////////////////////////////////////////////////

  // Enables and flags only pass when the slot is really valid
  always_comb begin
    pipe_d             = '0;
    pipe_d.instr_valid = id_valid_o;
    pipe_d.pc          = if_id_pipe_i.pc;
    pipe_d.operand_a   = operand_a_i;
    pipe_d.operand_b   = operand_b_i;
    pipe_d.rd          = decode_i.rd;
    if (id_valid_o) begin
      pipe_d.alu_en       = decode_i.alu_en;
      pipe_d.mul_en       = decode_i.mul_en;
      pipe_d.lsu_en       = decode_i.lsu_en;
      pipe_d.lsu_we       = decode_i.lsu_we;
      pipe_d.rf_we        = decode_i.rf_we;
      pipe_d.ecall_insn   = decode_i.ecall_insn;
      pipe_d.ebrk_insn    = decode_i.ebrk_insn;
      pipe_d.mret_insn    = decode_i.mret_insn;
      pipe_d.dret_insn    = decode_i.dret_insn;
      pipe_d.wfi_insn     = decode_i.wfi_insn;
      pipe_d.fencei_insn  = decode_i.fencei_insn;
      pipe_d.illegal_insn = decode_i.illegal_insn;
      pipe_d.csr_op       = decode_i.csr_op;
    end
  end

  // Holds while execute stalls, a kill always loads a bubble
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pipe_q <= '0;
    end else if (ex_ready_i || ctrl_fsm_i.kill_id) begin
      pipe_q <= pipe_d;
    end
  end

  assign id_ex_pipe_o = pipe_q;

endmodule

//--- verilog/rv_id_operands.sv
`timescale 1ns/1ns

module rv_id_operands
  import rv_id_pkg::*;
(
  input  decode_t  decode_i,
  input  logic     dummy_i,
  input  rf_data_t rdata_i [NUM_READ_PORTS],
  output rf_addr_t raddr_o [NUM_READ_PORTS],
  output rf_data_t operand_a_o,
  output rf_data_t operand_b_o
);

  // Register values after the x0 rule
  rf_data_t rs_val [NUM_READ_PORTS];

  assign raddr_o[0] = decode_i.rs1;
  assign raddr_o[1] = decode_i.rs2;

  // Normal instructions see zero for x0
  // A dummy instruction gets whatever was last written there
  for (genvar i = 0; i < NUM_READ_PORTS; i++) begin : gen_zero
    assign rs_val[i] = (raddr_o[i] == '0 && !dummy_i) ? '0 : rdata_i[i];
  end

  // Without an rs1 read, as for LUI, operand A is zero
  assign operand_a_o = decode_i.rf_re[0] ? rs_val[0] : '0;

  // Immediate has priority over the second read port
  always_comb begin
    if (decode_i.use_imm) begin
      operand_b_o = decode_i.imm;
    end else if (decode_i.rf_re[1]) begin
      operand_b_o = rs_val[1];
    end else begin
      operand_b_o = '0;
    end
  end

endmodule

//--- verilog/rv_id_regfile.sv
`timescale 1ns/1ns

module rv_id_regfile
  import rv_id_pkg::*;
(
  input  logic     clk,
  input  rf_addr_t raddr_i [NUM_READ_PORTS],
  output rf_data_t rdata_o [NUM_READ_PORTS],
  input  logic     we_i,
  input  rf_addr_t waddr_i,
  input  rf_data_t wdata_i
);

  // Flop array, x0 included so that dummy instructions can see its content
  rf_data_t mem [NUM_RF_REGS];

  //////////////////////////////////////////////////////////////////////
  // Write port
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (we_i) begin
      mem[waddr_i] <= wdata_i;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Read ports
  //////////////////////////////////////////////////////////////////////

  // Reads are combinational and return the old value during a same cycle write
  for (genvar i = 0; i < NUM_READ_PORTS; i++) begin : gen_read
    assign rdata_o[i] = mem[raddr_i[i]];
  end

endmodule

//--- decode/rv_id_decoder.sv
`timescale 1ns/1ns

module rv_id_decoder
  import rv_id_pkg::*;
(
  input  logic [31:0] instr_i,
  output decode_t     decode_o
);

  // Instruction fields
  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  logic [11:0] funct12;

  // Raw decode before the illegal override
  decode_t dec;
  logic    illegal;

  // Immediates in the three formats of the subset
  rf_data_t imm_i;
  rf_data_t imm_s;
  rf_data_t imm_u;

  assign opcode  = instr_i[6:0];
  assign funct3  = instr_i[14:12];
  assign funct7  = instr_i[31:25];
  assign funct12 = instr_i[31:20];

  assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_u = {instr_i[31:12], 12'b0};

  //////////////////////////////////////////////////////////////////////
  // Opcode decode
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    dec     = '0;
    dec.rs1 = instr_i[19:15];
    dec.rs2 = instr_i[24:20];
    dec.rd  = instr_i[11:7];
    illegal = 1'b0;

    case (opcode)
      OPC_OP: begin
        dec.rf_we = 1'b1;
        dec.rf_re = 2'b11;
        // Only MUL itself is taken from the M extension
        if (funct7 == 7'b0000001) begin
          if (funct3 == 3'b000) begin
            dec.mul_en = 1'b1;
          end else begin
            illegal = 1'b1;
          end
        end else if (funct7 == 7'b0000000) begin
          dec.alu_en = 1'b1;
        end else if (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101)) begin
          // SUB and SRA
          dec.alu_en = 1'b1;
        end else begin
          illegal = 1'b1;
        end
      end

      OPC_OP_IMM: begin
        dec.alu_en  = 1'b1;
        dec.rf_we   = 1'b1;
        dec.rf_re   = 2'b01;
        dec.use_imm = 1'b1;
        dec.imm     = imm_i;
        // Shifts carry a funct7 that must be well formed
        if (funct3 == 3'b001 && funct7 != 7'b0000000) begin
          illegal = 1'b1;
        end
        if (funct3 == 3'b101 && funct7 != 7'b0000000 && funct7 != 7'b0100000) begin
          illegal = 1'b1;
        end
      end

      OPC_LUI: begin
        // No source register, operand A becomes zero downstream
        dec.alu_en  = 1'b1;
        dec.rf_we   = 1'b1;
        dec.use_imm = 1'b1;
        dec.imm     = imm_u;
      end

      OPC_LOAD: begin
        dec.lsu_en  = 1'b1;
        dec.rf_we   = 1'b1;
        dec.rf_re   = 2'b01;
        dec.use_imm = 1'b1;
        dec.imm     = imm_i;
        // LB, LH, LW, LBU and LHU
        if (funct3 == 3'b011 || funct3 == 3'b110 || funct3 == 3'b111) begin
          illegal = 1'b1;
        end
      end

      OPC_STORE: begin
        dec.lsu_en  = 1'b1;
        dec.lsu_we  = 1'b1;
        dec.rf_re   = 2'b11;
        dec.use_imm = 1'b1;
        dec.imm     = imm_s;
        if (funct3[2] || funct3 == 3'b011) begin
          illegal = 1'b1;
        end
      end

      OPC_MISC_MEM: begin
        // FENCE.I only, a plain FENCE is outside the subset
        if (funct3 == 3'b001) begin
          dec.fencei_insn = 1'b1;
        end else begin
          illegal = 1'b1;
        end
      end

      OPC_SYSTEM: begin
        if (funct3 == 3'b000) begin
          // Privileged instructions need rs1 and rd at zero
          if (dec.rs1 != '0 || dec.rd != '0) begin
            illegal = 1'b1;
          end
          case (funct12)
            F12_ECALL:  dec.ecall_insn = 1'b1;
            F12_EBREAK: dec.ebrk_insn  = 1'b1;
            F12_MRET:   dec.mret_insn  = 1'b1;
            F12_DRET:   dec.dret_insn  = 1'b1;
            F12_WFI:    dec.wfi_insn   = 1'b1;
            default:    illegal        = 1'b1;
          endcase
        end else begin
          // Register forms of CSRRW, CSRRS and CSRRC; the CSR address rides as immediate
          dec.rf_we   = 1'b1;
          dec.rf_re   = 2'b01;
          dec.use_imm = 1'b1;
          dec.imm     = {20'b0, funct12};
          case (funct3)
            3'b001:  dec.csr_op = CSR_OP_WRITE;
            3'b010:  dec.csr_op = CSR_OP_SET;
            3'b011:  dec.csr_op = CSR_OP_CLEAR;
            default: illegal    = 1'b1;
          endcase
        end
      end

      default: begin
        illegal = 1'b1;
      end
    endcase

    // An illegal encoding leaves nothing active apart from its own flag
    decode_o = dec;
    if (illegal) begin
      decode_o              = '0;
      decode_o.illegal_insn = 1'b1;
    end
  end

endmodule

//--- common/rv_id_pkg.sv
package rv_id_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths and sizes
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned XLEN           = 32;
  localparam int unsigned NUM_RF_REGS    = 32;
  localparam int unsigned RF_ADDR_W      = 5;
  localparam int unsigned NUM_READ_PORTS = 2;

  // Major opcodes of the decoded subset
  localparam logic [6:0] OPC_OP       = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM   = 7'b0010011;
  localparam logic [6:0] OPC_LUI      = 7'b0110111;
  localparam logic [6:0] OPC_LOAD     = 7'b0000011;
  localparam logic [6:0] OPC_STORE    = 7'b0100011;
  localparam logic [6:0] OPC_MISC_MEM = 7'b0001111;
  localparam logic [6:0] OPC_SYSTEM   = 7'b1110011;

  // The funct12 field picks the privileged instruction when funct3 is zero
  localparam logic [11:0] F12_ECALL  = 12'h000;
  localparam logic [11:0] F12_EBREAK = 12'h001;
  localparam logic [11:0] F12_MRET   = 12'h302;
  localparam logic [11:0] F12_DRET   = 12'h7b2;
  localparam logic [11:0] F12_WFI    = 12'h105;

  //////////////////////////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////////////////////////

  typedef logic [RF_ADDR_W-1:0] rf_addr_t;
  typedef logic [XLEN-1:0]      rf_data_t;

  // READ is encoded as zero so a cleared struct carries no CSR write
  typedef enum logic [1:0] {
    CSR_OP_READ  = 2'b00,
    CSR_OP_WRITE = 2'b01,
    CSR_OP_SET   = 2'b10,
    CSR_OP_CLEAR = 2'b11
  } csr_opcode_e;

  typedef struct packed {
    logic dummy;
  } instr_meta_t;

  // Fetch to decode, 66 bits
  typedef struct packed {
    logic        instr_valid;
    logic [31:0] instr;
    logic [31:0] pc;
    instr_meta_t instr_meta;
  } if_id_pipe_t;

  typedef struct packed {
    logic halt_id;
    logic kill_id;
  } ctrl_fsm_t;

  // Combinational decoder result
  typedef struct packed {
    logic                      alu_en;
    logic                      mul_en;
    logic                      lsu_en;
    logic                      lsu_we;
    logic                      rf_we;
    logic                      ecall_insn;
    logic                      ebrk_insn;
    logic                      mret_insn;
    logic                      dret_insn;
    logic                      wfi_insn;
    logic                      fencei_insn;
    logic                      illegal_insn;
    csr_opcode_e               csr_op;
    logic [NUM_READ_PORTS-1:0] rf_re;
    rf_addr_t                  rs1;
    rf_addr_t                  rs2;
    rf_addr_t                  rd;
    logic                      use_imm;
    rf_data_t                  imm;
  } decode_t;

  // Decode to execute pipe register
  typedef struct packed {
    logic        instr_valid;
    logic [31:0] pc;
    rf_data_t    operand_a;
    rf_data_t    operand_b;
    rf_addr_t    rd;
    logic        alu_en;
    logic        mul_en;
    logic        lsu_en;
    logic        lsu_we;
    logic        rf_we;
    logic        ecall_insn;
    logic        ebrk_insn;
    logic        mret_insn;
    logic        dret_insn;
    logic        wfi_insn;
    logic        fencei_insn;
    logic        illegal_insn;
    csr_opcode_e csr_op;
  } id_ex_pipe_t;

endpackage
